/* Bender.yml */
package:
  name: nes_pad

dependencies: {}

sources:
  - hw/nes_pad_pkg.sv
  - hw/nes_line_filter.sv
  - hw/nes_pad_serializer.sv
  - hw/nes_pad_regs.sv
  - hw/nes_pad_top.sv
  - target: test
    files:
      - bench/nes_pad_tb.sv

# Top modules: nes_pad_top for synthesis, nes_pad_tb for simulation

/* bench/nes_pad_tb.sv */
`timescale 1ns/1ns

module nes_pad_tb import nes_pad_pkg::*; ();

    localparam int DEBOUNCE_CYCLES = 4;
    localparam int HOLD_CYCLES     = 16;
    localparam int LINE_HOLD       = 40;  // Console holds each line level this long
    localparam int ACK_TIMEOUT     = 20;
    localparam int SPIKE_BIT       = 4;   // Bit that sees the pulse spike

    logic       clk;
    logic       rst;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    nes_lines_t nes_in;
    logic       data;

    integer seed;
    int     checks;
    int     value_errs;
    int     timeouts;
    int     other_errs;
    int     polls_issued;  // Latches sent by the console model

    nes_pad_top #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
        .HOLD_CYCLES    (HOLD_CYCLES)
    ) nes_pad_top_i (
        .clk   (clk),
        .rst   (rst),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .nes_in(nes_in),
        .data  (data)
    );

    always #5 clk = ~clk;

    // Leaves the caller 1 ns after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_val(input string name, input logic [15:0] exp,
                             input logic [15:0] got);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
            value_errs++;
        end
    endtask

    // One classic cycle, stb dropped right after ack
    task automatic wb_access(input logic we, input logic [1:0] adr,
                             input logic [15:0] wdat, output logic [15:0] rdat);
        int   n;
        logic got_ack;
        got_ack    = 1'b0;
        rdat       = '0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        for (n = 0; n < ACK_TIMEOUT && !got_ack; n++) begin
            wait_cycles(1);
            if (wb_rsp.ack) begin
                got_ack = 1'b1;
                rdat    = wb_rsp.dat;  // Read data valid with ack
            end
        end
        wb_req = '0;
        checks++;
        assert (got_ack) else begin
            $display("Timeout: no Wishbone ack within %0d cycles at address %0d",
                     ACK_TIMEOUT, adr);
            timeouts++;
        end
        wait_cycles(1);
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [15:0] wdat);
        logic [15:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic check_reg(input string name, input logic [1:0] adr,
                             input logic [15:0] exp);
        logic [15:0] rdat;
        wb_access(1'b0, adr, 16'h0000, rdat);
        check_val(name, exp, rdat);
    endtask

    task automatic idle_between_polls();
        int gap;
        gap = 8 + ($unsigned($random(seed)) % 24);
        wait_cycles(gap);
    endtask

    // Console side: latch, then one pulse per bit, sampling data before each rise
    task automatic run_poll(input logic [7:0] pad, input logic [7:0] mid,
                            input logic do_mid, input logic glitch, input int pulses);
        nes_in.latch = 1'b1;
        wait_cycles(LINE_HOLD);
        nes_in.latch = 1'b0;
        polls_issued++;
        wait_cycles(LINE_HOLD);
        for (int k = 0; k < pulses; k++) begin
            if (glitch && k == SPIKE_BIT) begin
                nes_in.pulse = 1'b1;  // Short spike, filter must drop it
                wait_cycles(2);
                nes_in.pulse = 1'b0;
                wait_cycles(LINE_HOLD / 2);
            end
            check_val("data", {15'b0, ~pad[7-k]}, {15'b0, data});  // Active low
            if (k == 1) begin
                check_reg("REG_STATUS", REG_STATUS, 16'h0001);
            end
            nes_in.pulse = 1'b1;
            wait_cycles(LINE_HOLD);
            nes_in.pulse = 1'b0;
            if (do_mid && k == 2) begin
                wb_write(REG_BUTTONS, {8'h00, mid});  // Lands during the hold
            end
            wait_cycles(LINE_HOLD);
        end
        check_val("data", 16'h0001, {15'b0, data});  // Idle level after RIGHT
        check_reg("REG_STATUS", REG_STATUS, 16'h0000);
    endtask

    initial begin
        int          fd;
        int          scenarios;
        int          glitch;
        int          pulses;
        string       line;
        logic [7:0]  btn;
        logic [7:0]  mid;
        clk          = 1'b0;
        rst          = 1'b1;
        wb_req       = '0;
        nes_in       = '0;
        seed         = 32'h16208f5c;
        checks       = 0;
        value_errs   = 0;
        timeouts     = 0;
        other_errs   = 0;
        polls_issued = 0;
        scenarios    = 0;

        wait_cycles(16);
        rst = 1'b0;
        wait_cycles(2);

        check_val("data", 16'h0001, {15'b0, data});
        check_reg("REG_BUTTONS", REG_BUTTONS, 16'h0000);
        check_reg("REG_POLLS", REG_POLLS, 16'h0000);
        check_reg("REG_STATUS", REG_STATUS, 16'h0000);
        check_reg("unmapped", 2'd3, 16'h0000);

        fd = $fopen("bench/nes_pad_testdata.txt", "r");
        checks++;
        assert (fd != 0) else begin
            $display("Could not open the stimulus file bench/nes_pad_testdata.txt");
            other_errs++;
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0) begin
                    break;
                end
                if (line.len() == 0 || line.getc(0) == "#") begin
                    continue;  // Comment or blank
                end
                if ($sscanf(line, "%h %h %h %d", btn, mid, glitch, pulses) != 4) begin
                    continue;
                end
                scenarios++;
                wb_write(REG_BUTTONS, {8'h00, btn});
                run_poll(btn, mid, 1'b1, glitch[0], pulses);
                check_reg("REG_BUTTONS", REG_BUTTONS, {8'h00, mid});
                idle_between_polls();
                run_poll(mid, 8'h00, 1'b0, 1'b0, pulses);  // Mid-poll byte now visible
                check_reg("REG_POLLS", REG_POLLS, polls_issued[15:0]);
                idle_between_polls();
            end
            $fclose(fd);
        end
        checks++;
        assert (scenarios > 0) else begin
            $display("No scenarios were found in the stimulus file");
            other_errs++;
        end

        $display("Summary: %0d checks, %0d value errors, %0d timeouts, %0d other errors",
                 checks, value_errs, timeouts, other_errs);
        if (value_errs + timeouts + other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* bench/nes_pad_testdata.txt */
# buttons mid_poll glitch pulses
# Bytes in hex, glitch 1 adds a pulse spike, pulses in decimal
a5 5a 0 8
00 ff 1 8
ff 00 0 8
80 01 1 8
01 80 0 8
3c c3 1 8
96 69 0 8
f0 0f 1 8
12 ed 0 8
7e 81 1 8

/* hw/nes_line_filter.sv */
`timescale 1ns/1ns

module nes_line_filter import nes_pad_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = 20
) (
    input  logic       clk,
    input  logic       rst,
    input  nes_lines_t raw,
    output nes_lines_t clean
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [1:0]       sync_q1;    // First synchroniser stage
    logic [1:0]       sync_q2;    // Second stage, safe to use
    logic [1:0]       clean_q;
    logic [CNT_W-1:0] cnt_q [2];  // One debounce counter per line

    // Bit 1 is latch, bit 0 is pulse, same as the struct layout
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            clean_q <= '0;
            for (int i = 0; i < 2; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            sync_q1 <= raw;
            sync_q2 <= sync_q1;
            for (int i = 0; i < 2; i++) begin
                if (sync_q2[i] != clean_q[i]) begin
                    if (cnt_q[i] == CNT_W'(DEBOUNCE_CYCLES)) begin
                        clean_q[i] <= sync_q2[i];  // Stable long enough
                        cnt_q[i]   <= '0;
                    end else begin
                        cnt_q[i] <= cnt_q[i] + 1'b1;
                    end
                end else begin
                    cnt_q[i] <= '0;  // Glitch gone, start over
                end
            end
        end
    end

    assign clean = clean_q;

endmodule

/* hw/nes_pad_pkg.sv */
package nes_pad_pkg;

    localparam int WB_DW  = 16;  // Wishbone data width
    localparam int WB_AW  = 2;   // Word address bits
    localparam int PAD_W  = 8;   // Button register width
    localparam int POLL_W = 16;  // Poll counter width

    // One bit per button, 1 when pressed, A sits in the MSB
    typedef struct packed {
        logic a;
        logic b;
        logic select;
        logic start;
        logic up;
        logic down;
        logic left;
        logic right;
    } nes_pad_t;

    // Console strobes, raw or filtered
    typedef struct packed {
        logic latch;
        logic pulse;
    } nes_lines_t;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [WB_AW-1:0] adr;  // Word address
        logic [WB_DW-1:0] dat;  // Write data
    } wb_req_t;

    typedef struct packed {
        logic             ack;
        logic [WB_DW-1:0] dat;  // Read data, valid with ack
    } wb_rsp_t;

    // Address 3 is unmapped and reads as zero
    typedef enum logic [WB_AW-1:0] {
        REG_BUTTONS = 2'd0,  // RW, low 8 bits
        REG_POLLS   = 2'd1,  // RO, latch count
        REG_STATUS  = 2'd2   // RO, bit 0 busy
    } reg_addr_e;

    typedef enum logic [2:0] {
        IDLE,       // Data high, no poll
        LATCHED,    // Latch high, waiting for fall
        BIT_SHOWN,  // Bit on data, waiting for pulse
        HOLD,       // Keep bit after pulse fall
        NEXT_BIT    // Advance or finish
    } ser_state_e;

endpackage

/* hw/nes_pad_regs.sv */
`timescale 1ns/1ns

module nes_pad_regs import nes_pad_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  wb_req_t  wb_req,
    output wb_rsp_t  wb_rsp,
    input  logic     poll_start,
    input  logic     busy,
    output nes_pad_t pad_state
);

    reg_addr_e         addr;
    logic              req;        // Accepted transfer this cycle
    logic              ack_q;
    logic              done_q;     // Acked, waiting for stb low
    logic [WB_DW-1:0]  rd_mux;
    logic [WB_DW-1:0]  rd_dat_q;
    logic [PAD_W-1:0]  buttons_q;
    logic [POLL_W-1:0] polls_q;

    assign addr = reg_addr_e'(wb_req.adr);
    assign req  = wb_req.cyc & wb_req.stb & ~ack_q & ~done_q;

    always_comb begin
        rd_mux = '0;
        case (addr)
            REG_BUTTONS: rd_mux[PAD_W-1:0]  = buttons_q;
            REG_POLLS:   rd_mux[POLL_W-1:0] = polls_q;
            REG_STATUS:  rd_mux[0]          = busy;
            default:     rd_mux             = '0;  // Unmapped word
        endcase
    end

    // Single-cycle ack, then stay quiet until stb drops
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            ack_q  <= req;
            done_q <= (done_q | ack_q) & wb_req.cyc & wb_req.stb;
        end
    end

    // Read data lands together with ack
    always_ff @(posedge clk) begin
        if (req) begin
            rd_dat_q <= rd_mux;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            buttons_q <= '0;
        end else if (req && wb_req.we && addr == REG_BUTTONS) begin
            buttons_q <= wb_req.dat[PAD_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            polls_q <= '0;
        end else if (poll_start) begin
            polls_q <= polls_q + 1'b1;  // Wraps at 2^16
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_dat_q;
    assign pad_state  = buttons_q;

endmodule

/* hw/nes_pad_serializer.sv */
`timescale 1ns/1ns

module nes_pad_serializer import nes_pad_pkg::*; #(
    parameter int HOLD_CYCLES = 900
) (
    input  logic       clk,
    input  logic       rst,
    input  nes_lines_t lines,
    input  nes_pad_t   pad_state,
    output logic       data,
    output logic       poll_start,
    output logic       busy
);

    localparam int HOLD_W = $clog2(HOLD_CYCLES + 1);

    ser_state_e        state_q;
    nes_lines_t        lines_q;     // Previous filtered lines
    nes_pad_t          shift_q;     // Snapshot, next bit in MSB
    logic [2:0]        bit_idx_q;   // Bit currently on data
    logic [HOLD_W-1:0] hold_cnt_q;
    logic              latch_rise;
    logic              latch_fall;
    logic              pulse_fall;

    assign latch_rise = lines.latch & ~lines_q.latch;
    assign latch_fall = ~lines.latch & lines_q.latch;
    assign pulse_fall = ~lines.pulse & lines_q.pulse;

    // Snapshot taken at latch fall, later writes wait for the next poll
    always_ff @(posedge clk) begin
        if (state_q == LATCHED && latch_fall) begin
            shift_q <= pad_state;
        end else if (state_q == NEXT_BIT) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= IDLE;
            lines_q    <= '0;
            data       <= 1'b1;  // Inactive level
            poll_start <= 1'b0;
            busy       <= 1'b0;
            bit_idx_q  <= '0;
            hold_cnt_q <= '0;
        end else begin
            lines_q    <= lines;
            poll_start <= 1'b0;
            if (latch_rise) begin
                // A new latch always restarts the poll
                state_q <= LATCHED;
                data    <= 1'b1;
                busy    <= 1'b0;
            end else begin
                case (state_q)
                    IDLE: begin
                        data <= 1'b1;
                    end

                    LATCHED: begin
                        if (latch_fall) begin
                            data       <= ~pad_state.a;  // Bit A, active low
                            poll_start <= 1'b1;
                            busy       <= 1'b1;
                            bit_idx_q  <= '0;
                            state_q    <= BIT_SHOWN;
                        end
                    end

                    BIT_SHOWN: begin
                        if (pulse_fall) begin  // Console has clocked this bit
                            hold_cnt_q <= '0;
                            state_q    <= HOLD;
                        end
                    end

                    HOLD: begin
                        if (hold_cnt_q == HOLD_W'(HOLD_CYCLES - 1)) begin
                            state_q <= NEXT_BIT;
                        end else begin
                            hold_cnt_q <= hold_cnt_q + 1'b1;
                        end
                    end

                    NEXT_BIT: begin
                        if (bit_idx_q == 3'd7) begin
                            data    <= 1'b1;  // Right done, back to idle
                            busy    <= 1'b0;
                            state_q <= IDLE;
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            data      <= ~shift_q[6];  // Bit after the current MSB
                            state_q   <= BIT_SHOWN;
                        end
                    end

                    default: begin
                        state_q <= IDLE;
                    end
                endcase
            end
        end
    end

endmodule

/* hw/nes_pad_top.sv */
`timescale 1ns/1ns

module nes_pad_top import nes_pad_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = 20,
    parameter int HOLD_CYCLES     = 900
) (
    input  logic       clk,
    input  logic       rst,
    input  wb_req_t    wb_req,
    output wb_rsp_t    wb_rsp,
    input  nes_lines_t nes_in,
    output logic       data
);

    nes_lines_t nes_clean;   // Debounced latch and pulse
    nes_pad_t   pad_state;   // Host button byte
    logic       poll_start;  // Latch fall strobe
    logic       busy;

    nes_line_filter #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) nes_line_filter_i (
        .clk  (clk),
        .rst  (rst),
        .raw  (nes_in),
        .clean(nes_clean)
    );

    nes_pad_serializer #(
        .HOLD_CYCLES(HOLD_CYCLES)
    ) nes_pad_serializer_i (
        .clk       (clk),
        .rst       (rst),
        .lines     (nes_clean),
        .pad_state (pad_state),
        .data      (data),
        .poll_start(poll_start),
        .busy      (busy)
    );

    nes_pad_regs nes_pad_regs_i (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .poll_start(poll_start),
        .busy      (busy),
        .pad_state (pad_state)
    );

endmodule

/* vlog.f */
hw/nes_pad_pkg.sv
hw/nes_line_filter.sv
hw/nes_pad_serializer.sv
hw/nes_pad_regs.sv
hw/nes_pad_top.sv
bench/nes_pad_tb.sv
